//--- dv/rab_cfg_checker.sv
`timescale 1ns/100ps

module rab_cfg_checker (
  input logic Clk_CI,
  input logic Rst_RBI,
  input logic awready_i,
  input logic wready_i,
  input logic arready_i,
  input logic bvalid_i,
  input logic bready_i,
  input logic rvalid_i,
  input logic rready_i,
  input logic fifo_full_i
);

  // a response stays up until the master takes it
  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  assert property (@(posedge Clk_CI) disable iff (!Rst_RBI)
    bvalid_i |-> !awready_i)
    else $error("awready high while a write response is pending");

  // first edge out of reset
  assert property (@(posedge Clk_CI)
    $rose(Rst_RBI) |-> awready_i && wready_i && arready_i && !bvalid_i && !rvalid_i
                       && !fifo_full_i)
    else $error("handshake outputs wrong after reset");

endmodule

bind rab_cfg_top rab_cfg_checker i_rab_cfg_checker (
  .Clk_CI      (Clk_CI),
  .Rst_RBI     (Rst_RBI),
  .awready_i   (s_axi_awready_o),
  .wready_i    (s_axi_wready_o),
  .arready_i   (s_axi_arready_o),
  .bvalid_i    (s_axi_bvalid_o),
  .bready_i    (s_axi_bready_i),
  .rvalid_i    (s_axi_rvalid_o),
  .rready_i    (s_axi_rready_i),
  .fifo_full_i (mh_fifo_full_o)
);

//--- dv/tb_rab_cfg.sv
`timescale 1ns/100ps

module tb_rab_cfg;
  import rab_cfg_pkg::*;

  // about 20 cycles per L1 write with readback, 200 of them, plus the FIFO tests
  localparam int MAX_CYCLES = 20000;

  logic                              Clk_CI;
  logic                              Rst_RBI;
  logic [AXI_ADDR_W-1:0]             awaddr, araddr;
  logic                              awvalid, awready, wvalid, wready;
  logic [AXI_DATA_W-1:0]             wdata, rdata;
  logic [AXI_STRB_W-1:0]             wstrb;
  logic [1:0]                        bresp, rresp;
  logic                              bvalid, bready, arvalid, arready, rvalid, rready;
  logic [N_REGS-1:0][AXI_DATA_W-1:0] l1_cfg;
  logic                              miss, mh_full;
  logic [ADDR_WIDTH_VIRT-1:0]        miss_addr;
  logic [MISS_META_W-1:0]            miss_meta;

  logic [31:0]           seed = 32'h6c626fbe;
  logic [AXI_DATA_W-1:0] l1_model [N_REGS];
  logic [31:0]           addr_q [$]; // expected address FIFO
  logic [9:0]            meta_q [$];
  logic                  fifo_dis;
  string                 test_name = "";
  int                    err_cnt = 0;
  int                    err_mark = 0;
  int                    chk_cnt = 0;
  int                    test_cnt = 0;
  int                    cycle_cnt = 0;

  rab_cfg_top rab_cfg_top_inst (
    .Clk_CI, .Rst_RBI,
    .s_axi_awaddr_i  (awaddr),
    .s_axi_awvalid_i (awvalid),
    .s_axi_awready_o (awready),
    .s_axi_wdata_i   (wdata),
    .s_axi_wstrb_i   (wstrb),
    .s_axi_wvalid_i  (wvalid),
    .s_axi_wready_o  (wready),
    .s_axi_bresp_o   (bresp),
    .s_axi_bvalid_o  (bvalid),
    .s_axi_bready_i  (bready),
    .s_axi_araddr_i  (araddr),
    .s_axi_arvalid_i (arvalid),
    .s_axi_arready_o (arready),
    .s_axi_rdata_o   (rdata),
    .s_axi_rresp_o   (rresp),
    .s_axi_rvalid_o  (rvalid),
    .s_axi_rready_i  (rready),
    .l1_cfg_o        (l1_cfg),
    .miss_i          (miss),
    .miss_addr_i     (miss_addr),
    .miss_meta_i     (miss_meta),
    .mh_fifo_full_o  (mh_full)
  );

  always #5 Clk_CI = ~Clk_CI;

  always @(posedge Clk_CI)
  begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  function automatic logic [31:0] lcg();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // bits kept per word kind
  function automatic logic [63:0] kind_mask(int idx);
    case (idx % 4)
      0, 1:    return 64'h0000_0000_ffff_ffff;
      2:       return 64'h0000_00ff_ffff_ffff; // 40-bit physical
      default: return 64'h0000_0000_0000_000f;
    endcase
  endfunction

  task automatic compare(string name, logic [63:0] exp, logic [63:0] act);
    chk_cnt++;
    if (exp !== act)
    begin
      err_cnt++;
      $display("[ERROR] %s (%s): expected %h, actual %h", test_name, name, exp, act);
    end
  endtask

  task automatic end_test(string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  task automatic check_l1(string name);
    for (int i = 0; i < N_REGS; i++)
      compare(name, l1_model[i], l1_cfg[i]);
  endtask

  task automatic model_write(logic [31:0] addr, logic [63:0] data, logic [7:0] strb);
    int          idx;
    logic [63:0] w;
    if (addr >= L1_MAP_SIZE)
      return;
    idx = int'(addr[6:3]);
    w   = l1_model[idx];
    for (int b = 0; b < 8; b++)
      if (strb[b])
        w[8*b +: 8] = data[8*b +: 8];
    l1_model[idx] = w & kind_mask(idx);
    if (addr[6:0] == MH_CONF_OFFS)
      fifo_dis = data[0];
    else if (!fifo_dis && addr[6:0] == MH_ADDR_OFFS && addr_q.size() < MH_FIFO_DEPTH)
      addr_q.push_back(data[31:0]);
    else if (!fifo_dis && addr[6:0] == MH_META_OFFS && meta_q.size() < MH_FIFO_DEPTH)
      meta_q.push_back(data[9:0]);
  endtask

  task automatic axi_write(logic [31:0] addr, logic [63:0] data, logic [7:0] strb);
    logic aw_pend;
    logic w_pend;
    int   w_dly;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    w_dly   = int'(lcg() % 3); // W may trail AW
    @(negedge Clk_CI);
    awaddr  = addr;
    awvalid = 1'b1;
    wdata   = data;
    wstrb   = strb;
    while (aw_pend || w_pend)
    begin
      if (w_dly > 0)
        w_dly--;
      else if (w_pend)
        wvalid = 1'b1;
      if (awvalid && awready)
        aw_pend = 1'b0; // taken at the next rising edge
      if (wvalid && wready)
        w_pend = 1'b0;
      @(negedge Clk_CI);
      if (!aw_pend)
        awvalid = 1'b0;
      if (!w_pend)
        wvalid = 1'b0;
    end
    while (!bvalid)
      @(negedge Clk_CI);
    repeat (lcg() % 3) @(negedge Clk_CI);
    compare("write response", 64'(AXI_RESP_OKAY), 64'(bresp));
    bready = 1'b1;
    @(negedge Clk_CI);
    bready = 1'b0;
  endtask

  task automatic axi_read(logic [31:0] addr, output logic [63:0] data);
    @(negedge Clk_CI);
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready)
      @(negedge Clk_CI);
    @(negedge Clk_CI);
    arvalid = 1'b0;
    while (!rvalid)
      @(negedge Clk_CI);
    repeat (lcg() % 3) @(negedge Clk_CI); // hold rready off a while
    rready = 1'b1;
    data   = rdata;
    compare("read response", 64'(AXI_RESP_OKAY), 64'(rresp));
    @(negedge Clk_CI);
    rready = 1'b0;
  endtask

  task automatic send_miss(string name);
    logic [31:0] r;
    logic        exp_full;
    logic        full_seen;
    r = lcg();
    @(negedge Clk_CI);
    miss      = 1'b1;
    miss_addr = lcg();
    miss_meta = r[9:0];
    exp_full  = !fifo_dis && (addr_q.size() >= MH_FIFO_DEPTH);
    @(posedge Clk_CI);
    full_seen = mh_full;
    @(negedge Clk_CI);
    miss = 1'b0;
    compare(name, 64'(exp_full), 64'(full_seen));
    if (!fifo_dis && !exp_full)
    begin
      addr_q.push_back(miss_addr);
      meta_q.push_back(miss_meta);
    end
    repeat (lcg() % 3) @(negedge Clk_CI);
  endtask

  // alternate address and metadata reads, then the empty flag
  task automatic drain_fifos(string name);
    logic [63:0] d;
    logic [63:0] exp_a;
    logic [63:0] exp_m;
    while (addr_q.size() > 0)
    begin
      exp_a = {32'b0, addr_q.pop_front()};
      exp_m = {54'b0, meta_q.pop_front()};
      axi_read(32'h00, d);
      compare(name, exp_a, d);
      axi_read(32'h08, d);
      compare(name, exp_m, d);
    end
    axi_read(32'h08, d);
    compare(name, 64'h8000_0000, d);
  endtask

  initial
  begin
    logic [63:0] d;
    logic [31:0] r;
    int          idx;
    int          n;
    Clk_CI    = 1'b0;
    Rst_RBI   = 1'b0;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wstrb     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    miss      = 1'b0;
    miss_addr = '0;
    miss_meta = '0;
    fifo_dis  = 1'b0;
    for (int i = 0; i < N_REGS; i++)
      l1_model[i] = '0;
    repeat (16) @(negedge Clk_CI);
    Rst_RBI = 1'b1;
    @(negedge Clk_CI);

    test_name = "reset";
    check_l1("reset");
    compare("reset", 64'd1, 64'(awready));
    compare("reset", 64'd1, 64'(wready));
    compare("reset", 64'd1, 64'(arready));
    compare("reset", 64'd0, 64'(bvalid));
    compare("reset", 64'd0, 64'(rvalid));
    compare("reset", 64'd0, 64'(mh_full));
    end_test("reset");

    test_name = "l1 writes";
    for (int i = 0; i < 200; i++)
    begin
      idx = 3 + int'(lcg() % 13); // words 3 to 15, clear of the miss window
      d   = {lcg(), lcg()};
      r   = lcg();
      axi_write(32'(idx * 8), d, r[7:0]);
      model_write(32'(idx * 8), d, r[7:0]);
      check_l1("l1 write");
      axi_read(32'(idx * 8), d);
      compare("l1 readback low", l1_model[idx], d);
      axi_read(32'(idx * 8 + 4), d);
      compare("l1 readback high", {32'b0, l1_model[idx][63:32]}, d);
    end
    end_test("l1 writes");

    test_name = "miss recording";
    n = 1 + int'(lcg() % (MH_FIFO_DEPTH - 1));
    repeat (n) send_miss("miss record");
    drain_fifos("miss record");
    end_test("miss recording");

    test_name = "disable";
    axi_write(32'h10, 64'd1, 8'hff);
    model_write(32'h10, 64'd1, 8'hff);
    axi_read(32'h10, d);
    compare("disable", 64'd1, d);
    repeat (3) send_miss("disable");
    axi_write(32'h10, 64'd0, 8'hff);
    model_write(32'h10, 64'd0, 8'hff);
    check_l1("disable");
    drain_fifos("disable");
    end_test("disable");

    test_name = "overflow";
    repeat (MH_FIFO_DEPTH + 3) send_miss("overflow");
    drain_fifos("overflow");
    end_test("overflow");

    test_name = "axi push";
    for (int i = 0; i < 4; i++)
    begin
      d = {lcg(), lcg()};
      axi_write(32'h00, d, 8'hff);
      model_write(32'h00, d, 8'hff);
      d = {lcg(), lcg()};
      axi_write(32'h08, d, 8'hff);
      model_write(32'h08, d, 8'hff);
      check_l1("axi push");
    end
    drain_fifos("axi push");
    end_test("axi push");

    $display("tests: %0d, checks: %0d, errors: %0d", test_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
  --top-module tb_rab_cfg -Mdir obj_dir -o sim_rab_cfg

out=$(./obj_dir/sim_rab_cfg)
echo "$out"

echo "$out" | grep -qF '*** TEST PASSED ***'

//--- source/axi_lite_slave.sv
`timescale 1ns/100ps

module axi_lite_slave (
  input  logic                               Clk_CI,
  input  logic                               Rst_RBI,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0] s_axi_awaddr_i,
  input  logic                               s_axi_awvalid_i,
  output logic                               s_axi_awready_o,
  input  logic [rab_cfg_pkg::AXI_DATA_W-1:0] s_axi_wdata_i,
  input  logic [rab_cfg_pkg::AXI_STRB_W-1:0] s_axi_wstrb_i,
  input  logic                               s_axi_wvalid_i,
  output logic                               s_axi_wready_o,
  output logic                               s_axi_bvalid_o,
  input  logic                               s_axi_bready_i,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0] s_axi_araddr_i,
  input  logic                               s_axi_arvalid_i,
  output logic                               s_axi_arready_o,
  output logic [rab_cfg_pkg::AXI_DATA_W-1:0] s_axi_rdata_o,
  output logic                               s_axi_rvalid_o,
  input  logic                               s_axi_rready_i,
  input  logic [rab_cfg_pkg::AXI_DATA_W-1:0] rd_data_i,
  output logic                               wr_commit_o,
  output logic [rab_cfg_pkg::AXI_ADDR_W-1:0] wr_addr_o,
  output logic [rab_cfg_pkg::AXI_DATA_W-1:0] wr_data_o,
  output logic [rab_cfg_pkg::AXI_STRB_W-1:0] wr_strb_o,
  output logic [rab_cfg_pkg::AXI_ADDR_W-1:0] rd_addr_o,
  output logic                               rd_valid_o,
  output logic                               rd_done_o
);
  import rab_cfg_pkg::*;

  logic                  aw_done_q;
  logic                  w_done_q;
  logic                  ar_done_q;
  logic                  b_running_q;
  logic                  both_dly_q;
  logic                  both_done;
  logic                  aw_acc;
  logic                  w_acc;
  logic                  ar_acc;
  logic                  b_fire;
  logic                  r_fire;
  logic [AXI_ADDR_W-1:0] awaddr_q;
  logic [AXI_DATA_W-1:0] wdata_q;
  logic [AXI_STRB_W-1:0] wstrb_q;
  logic [AXI_ADDR_W-1:0] araddr_q;

  assign aw_acc    = !aw_done_q && s_axi_awvalid_i;
  assign w_acc     = !w_done_q && s_axi_wvalid_i;
  assign ar_acc    = !ar_done_q && s_axi_arvalid_i;
  assign b_fire    = b_running_q && s_axi_bready_i;
  assign r_fire    = ar_done_q && s_axi_rready_i;
  assign both_done = aw_done_q && w_done_q;

  // write readies come back after the B handshake
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      aw_done_q   <= 1'b0;
      w_done_q    <= 1'b0;
      b_running_q <= 1'b0;
      both_dly_q  <= 1'b0;
    end
    else
    begin
      both_dly_q <= both_done;
      if (b_fire)
      begin
        aw_done_q   <= 1'b0;
        w_done_q    <= 1'b0;
        b_running_q <= 1'b0;
      end
      else
      begin
        if (aw_acc)
          aw_done_q <= 1'b1;
        if (w_acc)
          w_done_q <= 1'b1;
        // bvalid goes up together with the second half
        if ((aw_acc || aw_done_q) && (w_acc || w_done_q) && !b_running_q)
          b_running_q <= 1'b1;
      end
    end
  end

  // one read in flight, so rvalid follows the AR done flag
  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      ar_done_q <= 1'b0;
    else if (r_fire)
      ar_done_q <= 1'b0;
    else if (ar_acc)
      ar_done_q <= 1'b1;
  end

  always_ff @(posedge Clk_CI)
  begin
    if (aw_acc)
      awaddr_q <= s_axi_awaddr_i;
    if (w_acc)
    begin
      wdata_q <= s_axi_wdata_i;
      wstrb_q <= s_axi_wstrb_i;
    end
    if (ar_acc)
      araddr_q <= s_axi_araddr_i;
  end

  assign s_axi_awready_o = !aw_done_q;
  assign s_axi_wready_o  = !w_done_q;
  assign s_axi_bvalid_o  = b_running_q;
  assign s_axi_arready_o = !ar_done_q;
  assign s_axi_rvalid_o  = ar_done_q;
  assign s_axi_rdata_o   = ar_done_q ? rd_data_i : '0; // zero outside a beat

  assign wr_commit_o = both_done && !both_dly_q; // rise of both halves
  assign wr_addr_o   = awaddr_q;
  assign wr_data_o   = wdata_q;
  assign wr_strb_o   = wstrb_q;
  assign rd_addr_o   = araddr_q;
  assign rd_valid_o  = ar_done_q;
  assign rd_done_o   = r_fire;

endmodule

//--- source/l1_cfg_regs.sv
`timescale 1ns/100ps

module l1_cfg_regs (
  input  logic                                                   Clk_CI,
  input  logic                                                   Rst_RBI,
  input  logic                                                   wr_commit_i,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0]                     wr_addr_i,
  input  logic [rab_cfg_pkg::AXI_DATA_W-1:0]                     wr_data_i,
  input  logic [rab_cfg_pkg::AXI_STRB_W-1:0]                     wr_strb_i,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0]                     rd_addr_i,
  output logic [rab_cfg_pkg::N_REGS-1:0][rab_cfg_pkg::AXI_DATA_W-1:0] l1_cfg_o,
  output logic [rab_cfg_pkg::AXI_DATA_W-1:0]                     rd_data_o
);
  import rab_cfg_pkg::*;

  logic [N_REGS-1:0][AXI_DATA_W-1:0] cfg_q;
  logic [ADDR_MSB-ADDR_LSB:0]        wr_idx;
  logic [AXI_DATA_W-1:0]             wr_word;
  logic [AXI_DATA_W-1:0]             rd_word;

  // keep only the bits that the word kind defines
  function automatic logic [AXI_DATA_W-1:0] mask_word(cfg_kind_e kind,
                                                     logic [AXI_DATA_W-1:0] raw);
    cfg_word_u w_in;
    cfg_word_u w_out;
    w_in.raw  = raw;
    w_out.raw = '0;
    case (kind)
      VIRT_START, VIRT_END: w_out.virt.addr = w_in.virt.addr;
      PHYS:                 w_out.raw[ADDR_WIDTH_PHYS-1:0] = w_in.raw[ADDR_WIDTH_PHYS-1:0];
      default:              w_out.flag.flags = w_in.flag.flags;
    endcase
    return w_out.raw;
  endfunction

  assign wr_idx = wr_addr_i[ADDR_MSB:ADDR_LSB];

  // byte merge under the strobes
  always_comb
  begin
    wr_word = cfg_q[wr_idx];
    for (int b = 0; b < AXI_STRB_W; b++)
      if (wr_strb_i[b])
        wr_word[8*b +: 8] = wr_data_i[8*b +: 8];
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      cfg_q <= '0;
    else if (wr_commit_i && (wr_addr_i < L1_MAP_SIZE))
      cfg_q[wr_idx] <= mask_word(cfg_kind_e'(wr_idx[1:0]), wr_word);
  end

  always_comb
  begin
    for (int i = 0; i < N_REGS; i++)
      l1_cfg_o[i] = mask_word(cfg_kind_e'(i[1:0]), cfg_q[i]);
  end

  assign rd_word = l1_cfg_o[rd_addr_i[ADDR_MSB:ADDR_LSB]];

  // bit 2 selects the upper half for 32-bit masters
  assign rd_data_o = rd_addr_i[ADDR_LSB-1] ?
                     {{(AXI_DATA_W/2){1'b0}}, rd_word[AXI_DATA_W-1:AXI_DATA_W/2]} :
                     rd_word;

endmodule

//--- source/mh_fifo.sv
`timescale 1ns/100ps

module mh_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             Clk_CI,
  input  logic             Rst_RBI,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o,
  output logic             full_o
);

  logic [WIDTH-1:0]         mem_q [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr_q;
  logic [$clog2(DEPTH)-1:0] rd_ptr_q;
  logic [$clog2(DEPTH):0]   cnt_q;
  logic                     push_en;
  logic                     pop_en;

  function automatic logic [$clog2(DEPTH)-1:0] ptr_inc(logic [$clog2(DEPTH)-1:0] p);
    return (int'(p) == DEPTH - 1) ? '0 : p + 1'b1;
  endfunction

  assign empty_o = (cnt_q == '0);
  assign full_o  = (int'(cnt_q) == DEPTH);
  assign push_en = push_i && !full_o;  // dropped when full
  assign pop_en  = pop_i && !empty_o;
  assign data_o  = empty_o ? '0 : mem_q[rd_ptr_q]; // head falls through

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end
    else
    begin
      if (push_en)
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop_en)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push_en, pop_en})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  always_ff @(posedge Clk_CI)
  begin
    if (push_en)
      mem_q[wr_ptr_q] <= data_i;
  end

endmodule

//--- source/miss_handler.sv
`timescale 1ns/100ps

module miss_handler (
  input  logic                                    Clk_CI,
  input  logic                                    Rst_RBI,
  input  logic                                    miss_i,
  input  logic [rab_cfg_pkg::ADDR_WIDTH_VIRT-1:0] miss_addr_i,
  input  logic [rab_cfg_pkg::MISS_META_W-1:0]     miss_meta_i,
  input  logic                                    wr_commit_i,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0]      wr_addr_i,
  input  logic [rab_cfg_pkg::AXI_DATA_W-1:0]      wr_data_i,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0]      rd_addr_i,
  input  logic                                    rd_valid_i,
  input  logic                                    rd_done_i,
  output logic [rab_cfg_pkg::AXI_DATA_W-1:0]      rd_data_o,
  output logic                                    rd_hit_o,
  output logic                                    fifo_full_o
);
  import rab_cfg_pkg::*;

  logic                       fifos_dis_q;
  logic                       l1_commit;
  logic [ADDR_MSB:0]          wr_off;
  logic [ADDR_MSB:0]          rd_off;
  logic                       addr_push, meta_push;
  logic [ADDR_WIDTH_VIRT-1:0] addr_din, addr_head;
  logic [MISS_META_W-1:0]     meta_din, meta_head;
  logic                       addr_empty, addr_full;
  logic                       meta_empty, meta_full;
  logic                       hit_addr, hit_meta, hit_conf;

  assign l1_commit = wr_commit_i && (wr_addr_i < L1_MAP_SIZE);
  assign wr_off    = wr_addr_i[ADDR_MSB:0];
  assign rd_off    = rd_addr_i[ADDR_MSB:0];

  // a miss wins over an AXI push in the same cycle
  always_comb
  begin
    addr_push = 1'b0;
    meta_push = 1'b0;
    addr_din  = miss_addr_i;
    meta_din  = miss_meta_i;
    if (miss_i && !fifos_dis_q)
    begin
      addr_push = 1'b1;
      meta_push = 1'b1;
    end
    else if (l1_commit && !fifos_dis_q)
    begin
      addr_push = (wr_off == MH_ADDR_OFFS);
      meta_push = (wr_off == MH_META_OFFS);
      addr_din  = wr_data_i[ADDR_WIDTH_VIRT-1:0];
      meta_din  = wr_data_i[MISS_META_W-1:0];
    end
  end

  always_ff @(posedge Clk_CI or negedge Rst_RBI)
  begin
    if (!Rst_RBI)
      fifos_dis_q <= 1'b0; // enabled out of reset
    else if (l1_commit && (wr_off == MH_CONF_OFFS))
      fifos_dis_q <= wr_data_i[0];
  end

  assign fifo_full_o = (addr_push && addr_full) || (meta_push && meta_full);

  assign hit_addr = rd_valid_i && (rd_off == MH_ADDR_OFFS);
  assign hit_meta = rd_valid_i && (rd_off == MH_META_OFFS);
  assign hit_conf = rd_valid_i && (rd_off == MH_CONF_OFFS);
  assign rd_hit_o = hit_addr || hit_meta || hit_conf;

  always_comb
  begin
    rd_data_o = '0;
    if (hit_addr)
      rd_data_o[ADDR_WIDTH_VIRT-1:0] = addr_head;
    else if (hit_meta)
    begin
      rd_data_o[META_EMPTY_BIT]    = meta_empty;
      rd_data_o[MISS_META_W-1:0]   = meta_head;
    end
    else if (hit_conf)
      rd_data_o[0] = fifos_dis_q;
  end

  mh_fifo #(.WIDTH(ADDR_WIDTH_VIRT), .DEPTH(MH_FIFO_DEPTH)) i_addr_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (addr_push),
    .data_i  (addr_din),
    .pop_i   (rd_done_i && hit_addr && !addr_empty), // pop on the R handshake
    .data_o  (addr_head),
    .empty_o (addr_empty),
    .full_o  (addr_full)
  );

  mh_fifo #(.WIDTH(MISS_META_W), .DEPTH(MH_FIFO_DEPTH)) i_meta_fifo (
    .Clk_CI  (Clk_CI),
    .Rst_RBI (Rst_RBI),
    .push_i  (meta_push),
    .data_i  (meta_din),
    .pop_i   (rd_done_i && hit_meta && !meta_empty),
    .data_o  (meta_head),
    .empty_o (meta_empty),
    .full_o  (meta_full)
  );

endmodule

//--- source/rab_cfg_pkg.sv
package rab_cfg_pkg;

  // AXI4-Lite bus
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64; // also the slice word width
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // slice configuration bank
  localparam int N_SLICES = 4;
  localparam int N_REGS   = 4 * N_SLICES; // four words per slice
  localparam int ADDR_LSB = 3;
  localparam int ADDR_MSB = ADDR_LSB + $clog2(N_REGS) - 1;

  localparam logic [AXI_ADDR_W-1:0] L1_MAP_SIZE = 32'h0000_4000;

  localparam int ADDR_WIDTH_VIRT = 32;
  localparam int ADDR_WIDTH_PHYS = 40;
  localparam int N_FLAGS         = 4;

  // miss handling
  localparam int MISS_META_W   = 10;
  localparam int MH_FIFO_DEPTH = 8;

  localparam logic [ADDR_MSB:0] MH_ADDR_OFFS = 7'h00;
  localparam logic [ADDR_MSB:0] MH_META_OFFS = 7'h08;
  localparam logic [ADDR_MSB:0] MH_CONF_OFFS = 7'h10;
  localparam int                META_EMPTY_BIT = 31;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  // word kind from index bits 1:0
  typedef enum logic [1:0] {VIRT_START, VIRT_END, PHYS, FLAGS} cfg_kind_e;

  typedef union packed {
    logic [AXI_DATA_W-1:0] raw;
    struct packed {
      logic [AXI_DATA_W-ADDR_WIDTH_VIRT-1:0] pad;
      logic [ADDR_WIDTH_VIRT-1:0]            addr;
    } virt;
    struct packed {
      logic [AXI_DATA_W-N_FLAGS-1:0] pad;
      logic [N_FLAGS-1:0]            flags;
    } flag;
  } cfg_word_u;

endpackage

//--- source/rab_cfg_top.sv
`timescale 1ns/100ps

module rab_cfg_top (
  input  logic                                    Clk_CI,
  input  logic                                    Rst_RBI,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0]      s_axi_awaddr_i,
  input  logic                                    s_axi_awvalid_i,
  output logic                                    s_axi_awready_o,
  input  logic [rab_cfg_pkg::AXI_DATA_W-1:0]      s_axi_wdata_i,
  input  logic [rab_cfg_pkg::AXI_STRB_W-1:0]      s_axi_wstrb_i,
  input  logic                                    s_axi_wvalid_i,
  output logic                                    s_axi_wready_o,
  output logic [1:0]                              s_axi_bresp_o,
  output logic                                    s_axi_bvalid_o,
  input  logic                                    s_axi_bready_i,
  input  logic [rab_cfg_pkg::AXI_ADDR_W-1:0]      s_axi_araddr_i,
  input  logic                                    s_axi_arvalid_i,
  output logic                                    s_axi_arready_o,
  output logic [rab_cfg_pkg::AXI_DATA_W-1:0]      s_axi_rdata_o,
  output logic [1:0]                              s_axi_rresp_o,
  output logic                                    s_axi_rvalid_o,
  input  logic                                    s_axi_rready_i,
  output logic [rab_cfg_pkg::N_REGS-1:0][rab_cfg_pkg::AXI_DATA_W-1:0] l1_cfg_o,
  input  logic                                    miss_i,
  input  logic [rab_cfg_pkg::ADDR_WIDTH_VIRT-1:0] miss_addr_i,
  input  logic [rab_cfg_pkg::MISS_META_W-1:0]     miss_meta_i,
  output logic                                    mh_fifo_full_o
);
  import rab_cfg_pkg::*;

  logic                  wr_commit, rd_valid, rd_done, mh_rd_hit;
  logic [AXI_ADDR_W-1:0] wr_addr, rd_addr;
  logic [AXI_DATA_W-1:0] wr_data, rd_data, l1_rdata, mh_rdata;
  logic [AXI_STRB_W-1:0] wr_strb;

  assign rd_data       = mh_rd_hit ? mh_rdata : l1_rdata; // miss window first
  assign s_axi_bresp_o = AXI_RESP_OKAY;
  assign s_axi_rresp_o = AXI_RESP_OKAY;

  axi_lite_slave i_axi_lite_slave (
    .Clk_CI, .Rst_RBI,
    .s_axi_awaddr_i, .s_axi_awvalid_i, .s_axi_awready_o,
    .s_axi_wdata_i, .s_axi_wstrb_i, .s_axi_wvalid_i, .s_axi_wready_o,
    .s_axi_bvalid_o, .s_axi_bready_i,
    .s_axi_araddr_i, .s_axi_arvalid_i, .s_axi_arready_o,
    .s_axi_rdata_o, .s_axi_rvalid_o, .s_axi_rready_i,
    .rd_data_i   (rd_data),
    .wr_commit_o (wr_commit),
    .wr_addr_o   (wr_addr),
    .wr_data_o   (wr_data),
    .wr_strb_o   (wr_strb),
    .rd_addr_o   (rd_addr),
    .rd_valid_o  (rd_valid),
    .rd_done_o   (rd_done)
  );

  l1_cfg_regs i_l1_cfg_regs (
    .Clk_CI, .Rst_RBI,
    .wr_commit_i (wr_commit),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_strb_i   (wr_strb),
    .rd_addr_i   (rd_addr),
    .l1_cfg_o,
    .rd_data_o   (l1_rdata)
  );

  miss_handler i_miss_handler (
    .Clk_CI, .Rst_RBI,
    .miss_i, .miss_addr_i, .miss_meta_i,
    .wr_commit_i (wr_commit),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .rd_addr_i   (rd_addr),
    .rd_valid_i  (rd_valid),
    .rd_done_i   (rd_done),
    .rd_data_o   (mh_rdata),
    .rd_hit_o    (mh_rd_hit),
    .fifo_full_o (mh_fifo_full_o)
  );

endmodule

//--- sources.f
source/rab_cfg_pkg.sv
source/axi_lite_slave.sv
source/l1_cfg_regs.sv
source/mh_fifo.sv
source/miss_handler.sv
source/rab_cfg_top.sv
dv/rab_cfg_checker.sv
dv/tb_rab_cfg.sv
